// ==== bridge_proto_pkg.sv ====
package bridge_proto_pkg;

  // Basic data widths
  localparam int BYTE_W = 8;
  localparam int WORD_W = 32;
  localparam int WORD_BYTES = WORD_W / BYTE_W;

  // Requests carry a full 16-bit word address from the header
  localparam int REQ_ADDR_W = 16;

  // Opcodes, first byte of every bulk OUT frame
  localparam logic [BYTE_W-1:0] OP_WRITE = 8'h57;  // ASCII 'W'
  localparam logic [BYTE_W-1:0] OP_READ = 8'h52;  // ASCII 'R'

  // Header layout: opcode, address low, address high, count
  localparam int HDR_BYTES = 4;
  localparam int HDR_OP = 0;
  localparam int HDR_ADDR_LO = 1;
  localparam int HDR_ADDR_HI = 2;
  localparam int HDR_COUNT = 3;  // Read length in words, 0 means 256

  // Default sizing, 512 words is the 2048-byte store
  localparam int DEF_ADDR_WIDTH = 9;
  localparam int DEF_FIFO_DEPTH = 4;

endpackage

// ==== bridge_types_pkg.sv ====
package bridge_types_pkg;

  // One word request from the frame decoder to the store
  typedef struct packed {
    logic                                    write_en;  // Low for a read
    logic [bridge_proto_pkg::REQ_ADDR_W-1:0] addr;      // Store uses the low bits
    logic [bridge_proto_pkg::WORD_W-1:0]     wdata;
    logic                                    last;      // Final word of a read frame
  } mem_req_t;

  // Read result on its way to the bulk IN serializer
  typedef struct packed {
    logic [bridge_proto_pkg::WORD_W-1:0] rdata;
    logic                                last;  // Closes the bulk IN transfer
  } mem_rsp_t;

endpackage

// ==== stream_fifo.sv ====
module stream_fifo #(
  parameter int DEPTH = bridge_proto_pkg::DEF_FIFO_DEPTH,
  parameter type payload_t = logic [7:0]
) (
  input  logic                             clock_i,
  input  logic                             rst_n_i,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  input  payload_t                         in_data_i,
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output payload_t                         out_data_o,
  output logic [$clog2(DEPTH + 1) - 1:0]   count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic push_w;
  logic pop_w;

  // Pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o = (count_q != CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_data_o = mem_q[rd_ptr_q];  // Head entry, valid while not empty
  assign count_o = count_q;

  assign push_w = in_valid_i && in_ready_o;
  assign pop_w = out_valid_o && out_ready_i;

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push_w) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_w) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_w, pop_w})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if (push_w) mem_q[wr_ptr_q] <= in_data_i;
  end

endmodule

// ==== bulk_frame_decoder.sv ====
module bulk_frame_decoder #(
  parameter int ADDR_WIDTH = bridge_proto_pkg::DEF_ADDR_WIDTH
) (
  input  logic                                clock_i,
  input  logic                                rst_n_i,
  input  logic                                s_tvalid_i,
  output logic                                s_tready_o,
  input  logic                                s_tlast_i,
  input  logic [bridge_proto_pkg::BYTE_W-1:0] s_tdata_i,
  output logic                                req_valid_o,
  input  logic                                req_ready_i,
  output bridge_types_pkg::mem_req_t          req_data_o,
  output logic                                proto_error_o
);

  localparam int BW = bridge_proto_pkg::BYTE_W;
  localparam int WW = bridge_proto_pkg::WORD_W;
  localparam int RAW = bridge_proto_pkg::REQ_ADDR_W;
  localparam int IDX_W = $clog2(bridge_proto_pkg::WORD_BYTES);
  localparam int HDR_W = $clog2(bridge_proto_pkg::HDR_BYTES);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(bridge_proto_pkg::WORD_BYTES - 1);
  localparam logic [HDR_W-1:0] H_OP = HDR_W'(bridge_proto_pkg::HDR_OP);
  localparam logic [HDR_W-1:0] H_LO = HDR_W'(bridge_proto_pkg::HDR_ADDR_LO);
  localparam logic [HDR_W-1:0] H_HI = HDR_W'(bridge_proto_pkg::HDR_ADDR_HI);
  localparam logic [HDR_W-1:0] H_CNT = HDR_W'(bridge_proto_pkg::HDR_COUNT);

  typedef enum logic [1:0] {
    ST_HDR,
    ST_WR,    // Write payload bytes
    ST_RD,    // Issuing read requests, bulk OUT stalled
    ST_DROP   // Discard until tlast
  } state_t;

  state_t state_q;
  logic [HDR_W-1:0] hdr_idx_q;
  logic [IDX_W-1:0] byte_idx_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [BW:0] remain_q;  // Read words left, up to 256
  logic tail_q;           // Read frame still has bytes before tlast
  logic err_q;
  logic req_valid_q;
  bridge_types_pkg::mem_req_t req_q;
  logic [BW-1:0] op_q;
  logic [BW-1:0] addr_lo_q;
  logic [WW-1:0] word_q;
  logic [WW-1:0] word_w;
  logic req_free_w;
  logic byte_acc_w;
  logic op_ok_w;
  logic wr_issue_w;
  logic rd_issue_w;

  // Request slot is free when empty or being taken this cycle
  assign req_free_w = !req_valid_q || req_ready_i;
  assign s_tready_o = (state_q == ST_HDR) || (state_q == ST_DROP) ||
                      ((state_q == ST_WR) && req_free_w);
  assign byte_acc_w = s_tvalid_i && s_tready_o;
  assign op_ok_w = (s_tdata_i == bridge_proto_pkg::OP_WRITE) ||
                   (s_tdata_i == bridge_proto_pkg::OP_READ);
  assign wr_issue_w = (state_q == ST_WR) && byte_acc_w &&
                      ((byte_idx_q == IDX_LAST) || s_tlast_i);
  assign rd_issue_w = (state_q == ST_RD) && req_free_w;

  always_comb begin
    word_w = word_q;
    word_w[byte_idx_q * BW +: BW] = s_tdata_i;  // LSB first
  end

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_HDR;
      hdr_idx_q <= '0;
      byte_idx_q <= '0;
      addr_q <= '0;
      remain_q <= '0;
      tail_q <= 1'b0;
      err_q <= 1'b0;
      req_valid_q <= 1'b0;
    end else begin
      if (req_valid_q && req_ready_i) req_valid_q <= 1'b0;
      case (state_q)
        ST_HDR: if (byte_acc_w) begin
          hdr_idx_q <= hdr_idx_q + 1'b1;
          if (hdr_idx_q == H_HI) addr_q <= ADDR_WIDTH'({s_tdata_i, addr_lo_q});
          if ((hdr_idx_q == H_OP) && !op_ok_w) begin
            err_q <= 1'b1;
            hdr_idx_q <= '0;
            state_q <= s_tlast_i ? ST_HDR : ST_DROP;
          end else if (s_tlast_i && (hdr_idx_q != H_CNT)) begin
            err_q <= 1'b1;  // Frame shorter than its header
            hdr_idx_q <= '0;
          end else if (hdr_idx_q == H_CNT) begin
            hdr_idx_q <= '0;
            byte_idx_q <= '0;
            if (op_q == bridge_proto_pkg::OP_WRITE) begin
              state_q <= s_tlast_i ? ST_HDR : ST_WR;
            end else begin
              state_q <= ST_RD;
              remain_q <= (s_tdata_i == '0) ? {1'b1, {BW{1'b0}}} : {1'b0, s_tdata_i};
              tail_q <= !s_tlast_i;
            end
          end
        end
        ST_WR: if (byte_acc_w) begin
          byte_idx_q <= byte_idx_q + 1'b1;
          if (wr_issue_w) begin
            req_valid_q <= 1'b1;
            addr_q <= addr_q + 1'b1;  // Wraps at the top of the store
            byte_idx_q <= '0;
          end
          if (s_tlast_i) state_q <= ST_HDR;
        end
        ST_RD: if (rd_issue_w) begin
          req_valid_q <= 1'b1;
          addr_q <= addr_q + 1'b1;
          remain_q <= remain_q - 1'b1;
          if (remain_q == (BW + 1)'(1)) state_q <= tail_q ? ST_DROP : ST_HDR;
        end
        default: if (byte_acc_w && s_tlast_i) state_q <= ST_HDR;
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if ((state_q == ST_HDR) && byte_acc_w && (hdr_idx_q == H_OP)) op_q <= s_tdata_i;
    if ((state_q == ST_HDR) && byte_acc_w && (hdr_idx_q == H_LO)) addr_lo_q <= s_tdata_i;
    if (state_q == ST_HDR) word_q <= '0;
    else if ((state_q == ST_WR) && byte_acc_w) word_q <= wr_issue_w ? '0 : word_w;
    if (wr_issue_w) begin
      req_q <= '{write_en: 1'b1, addr: RAW'(addr_q), wdata: word_w, last: 1'b0};
    end else if (rd_issue_w) begin
      req_q <= '{write_en: 1'b0, addr: RAW'(addr_q), wdata: '0,
                 last: (remain_q == (BW + 1)'(1))};
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_data_o = req_q;
  assign proto_error_o = err_q;  // Sticky until reset

endmodule

// ==== word_store.sv ====
module word_store #(
  parameter int ADDR_WIDTH = bridge_proto_pkg::DEF_ADDR_WIDTH,
  parameter int FIFO_DEPTH = bridge_proto_pkg::DEF_FIFO_DEPTH
) (
  input  logic                                  clock_i,
  input  logic                                  rst_n_i,
  input  logic                                  req_valid_i,
  output logic                                  req_ready_o,
  input  bridge_types_pkg::mem_req_t            req_data_i,
  output logic                                  rsp_valid_o,
  output bridge_types_pkg::mem_rsp_t            rsp_data_o,
  input  logic [$clog2(FIFO_DEPTH + 1) - 1:0]   rsp_count_i
);

  localparam int WW = bridge_proto_pkg::WORD_W;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [WW-1:0] mem_q [2 ** ADDR_WIDTH];
  logic [ADDR_WIDTH-1:0] idx_w;
  logic rd_v1_q;
  logic rd_v2_q;
  logic [WW-1:0] rd_word1_q;
  logic rd_last1_q;
  bridge_types_pkg::mem_rsp_t rsp_q;
  logic [CNT_W-1:0] inflight_q;
  logic [CNT_W:0] used_w;
  logic credit_ok_w;
  logic acc_w;
  logic rd_acc_w;

  assign idx_w = req_data_i.addr[ADDR_WIDTH-1:0];

  // Response FIFO entries plus reads in the pipe must leave room for one more
  assign used_w = {1'b0, rsp_count_i} + {1'b0, inflight_q};
  assign credit_ok_w = (used_w < (CNT_W + 1)'(FIFO_DEPTH));

  assign req_ready_o = req_data_i.write_en || credit_ok_w;  // Writes never wait
  assign acc_w = req_valid_i && req_ready_o;
  assign rd_acc_w = acc_w && !req_data_i.write_en;

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_v1_q <= 1'b0;
      rd_v2_q <= 1'b0;
      inflight_q <= '0;
    end else begin
      rd_v1_q <= rd_acc_w;
      rd_v2_q <= rd_v1_q;
      // A read leaves the count when it is pushed into the response FIFO
      case ({rd_acc_w, rd_v2_q})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if (acc_w && req_data_i.write_en) mem_q[idx_w] <= req_data_i.wdata;
    // Stage 1, RAM read
    if (rd_acc_w) begin
      rd_word1_q <= mem_q[idx_w];
      rd_last1_q <= req_data_i.last;
    end
    // Stage 2, output register
    if (rd_v1_q) rsp_q <= '{rdata: rd_word1_q, last: rd_last1_q};
  end

  assign rsp_valid_o = rd_v2_q;
  assign rsp_data_o = rsp_q;

endmodule

// ==== bulk_in_serializer.sv ====
module bulk_in_serializer (
  input  logic                                clock_i,
  input  logic                                rst_n_i,
  input  logic                                rsp_valid_i,
  output logic                                rsp_ready_o,
  input  bridge_types_pkg::mem_rsp_t          rsp_data_i,
  output logic                                m_tvalid_o,
  input  logic                                m_tready_i,
  output logic                                m_tlast_o,
  output logic [bridge_proto_pkg::BYTE_W-1:0] m_tdata_o
);

  localparam int BW = bridge_proto_pkg::BYTE_W;
  localparam int WW = bridge_proto_pkg::WORD_W;
  localparam int IDX_W = $clog2(bridge_proto_pkg::WORD_BYTES);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(bridge_proto_pkg::WORD_BYTES - 1);

  logic busy_q;
  logic [IDX_W-1:0] idx_q;
  logic [WW-1:0] sh_q;
  logic last_q;
  logic byte_acc_w;
  logic word_end_w;
  logic load_w;

  assign word_end_w = (idx_q == IDX_LAST);
  assign byte_acc_w = busy_q && m_tready_i;

  // Next word may load while the final byte of the current one leaves
  assign rsp_ready_o = !busy_q || (byte_acc_w && word_end_w);
  assign load_w = rsp_valid_i && rsp_ready_o;

  assign m_tvalid_o = busy_q;
  assign m_tdata_o = sh_q[BW-1:0];
  assign m_tlast_o = busy_q && last_q && word_end_w;

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      idx_q <= '0;
    end else if (load_w) begin
      busy_q <= 1'b1;
      idx_q <= '0;
    end else if (byte_acc_w) begin
      idx_q <= idx_q + 1'b1;
      if (word_end_w) busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clock_i) begin
    if (load_w) begin
      sh_q <= rsp_data_i.rdata;
      last_q <= rsp_data_i.last;
    end else if (byte_acc_w) begin
      sh_q <= sh_q >> BW;  // Next byte up, LSB first
    end
  end

endmodule

// ==== bulk_mem_bridge.sv ====
module bulk_mem_bridge #(
  parameter int ADDR_WIDTH = bridge_proto_pkg::DEF_ADDR_WIDTH,
  parameter int FIFO_DEPTH = bridge_proto_pkg::DEF_FIFO_DEPTH
) (
  input  logic                                clock_i,  // USB bus clock
  input  logic                                rst_n_i,

  // Bulk OUT from the host
  input  logic                                s_tvalid_i,
  output logic                                s_tready_o,
  input  logic                                s_tlast_i,
  input  logic [bridge_proto_pkg::BYTE_W-1:0] s_tdata_i,

  // Bulk IN to the host
  output logic                                m_tvalid_o,
  input  logic                                m_tready_i,
  output logic                                m_tlast_o,
  output logic [bridge_proto_pkg::BYTE_W-1:0] m_tdata_o,

  output logic                                proto_error_o
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Decoder to request FIFO
  logic dec_valid_w;
  logic dec_ready_w;
  bridge_types_pkg::mem_req_t dec_data_w;

  // Request FIFO to store
  logic req_valid_w;
  logic req_ready_w;
  bridge_types_pkg::mem_req_t req_data_w;

  // Store to response FIFO, no ready since credits cover it
  logic st_valid_w;
  bridge_types_pkg::mem_rsp_t st_data_w;
  logic [CNT_W-1:0] rsp_count_w;

  // Response FIFO to serializer
  logic rsp_valid_w;
  logic rsp_ready_w;
  bridge_types_pkg::mem_rsp_t rsp_data_w;

  bulk_frame_decoder #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) decoder_inst (
    .clock_i      (clock_i),
    .rst_n_i      (rst_n_i),
    .s_tvalid_i   (s_tvalid_i),
    .s_tready_o   (s_tready_o),
    .s_tlast_i    (s_tlast_i),
    .s_tdata_i    (s_tdata_i),
    .req_valid_o  (dec_valid_w),
    .req_ready_i  (dec_ready_w),
    .req_data_o   (dec_data_w),
    .proto_error_o(proto_error_o)
  );

  stream_fifo #(
    .DEPTH    (FIFO_DEPTH),
    .payload_t(bridge_types_pkg::mem_req_t)
  ) req_fifo (
    .clock_i    (clock_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (dec_valid_w),
    .in_ready_o (dec_ready_w),
    .in_data_i  (dec_data_w),
    .out_valid_o(req_valid_w),
    .out_ready_i(req_ready_w),
    .out_data_o (req_data_w),
    .count_o    ()
  );

  word_store #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) store_inst (
    .clock_i    (clock_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(req_valid_w),
    .req_ready_o(req_ready_w),
    .req_data_i (req_data_w),
    .rsp_valid_o(st_valid_w),
    .rsp_data_o (st_data_w),
    .rsp_count_i(rsp_count_w)
  );

  stream_fifo #(
    .DEPTH    (FIFO_DEPTH),
    .payload_t(bridge_types_pkg::mem_rsp_t)
  ) rsp_fifo (
    .clock_i    (clock_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (st_valid_w),
    .in_ready_o (),  // Never full when the store pushes
    .in_data_i  (st_data_w),
    .out_valid_o(rsp_valid_w),
    .out_ready_i(rsp_ready_w),
    .out_data_o (rsp_data_w),
    .count_o    (rsp_count_w)
  );

  bulk_in_serializer serializer_inst (
    .clock_i    (clock_i),
    .rst_n_i    (rst_n_i),
    .rsp_valid_i(rsp_valid_w),
    .rsp_ready_o(rsp_ready_w),
    .rsp_data_i (rsp_data_w),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .m_tlast_o  (m_tlast_o),
    .m_tdata_o  (m_tdata_o)
  );

endmodule

// ==== tb_host_tasks.svh ====
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
  return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

// Eight steps, first bit taken ends up in bit 0
function automatic logic [7:0] random_byte();
  logic [7:0] value;
  value = '0;
  repeat (8) begin
    value = {data_lfsr[0], value[7:1]};
    data_lfsr = lfsr_next(data_lfsr);
  end
  return value;
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
  end
endtask

// Byte is taken at the posedge after a negedge that sees ready high
task automatic send_byte(input logic [7:0] value, input logic last);
  int waited;
  @(posedge clock_i);
  s_tvalid_i <= 1'b1;
  s_tdata_i <= value;
  s_tlast_i <= last;
  waited = 0;
  @(negedge clock_i);
  while (!s_tready_o && waited < 2000) begin
    @(negedge clock_i);
    waited++;
  end
  if (!s_tready_o) begin
    $display("Timeout at %0t, bulk OUT byte was never accepted", $time);
    timeout_count++;
  end
endtask

task automatic send_frame();
  int i;
  for (i = 0; i < frame_q.size(); i++) begin
    send_byte(frame_q[i], i == frame_q.size() - 1);
  end
  @(posedge clock_i);  // Last byte goes at this edge
  s_tvalid_i <= 1'b0;
  s_tlast_i <= 1'b0;
  frame_q.delete();
endtask

task automatic push_header(input logic [7:0] op, input int addr, input int count);
  frame_q.push_back(op);
  frame_q.push_back(8'(addr));
  frame_q.push_back(8'(addr >> 8));
  frame_q.push_back(8'(count));
endtask

task automatic wait_read_done(input int limit);
  int waited;
  waited = 0;
  while (exp_data_q.size() != 0 && waited < limit) begin
    @(negedge clock_i);
    waited++;
  end
  if (exp_data_q.size() != 0) begin
    $display("Timeout at %0t, %0d bulk IN bytes never arrived", $time, exp_data_q.size());
    timeout_count++;
    exp_data_q.delete();
    exp_last_q.delete();
  end
endtask

task automatic wait_for_error(input int limit);
  int waited;
  waited = 0;
  while (!proto_error_o && waited < limit) begin
    @(negedge clock_i);
    waited++;
  end
  if (!proto_error_o) begin
    $display("Timeout at %0t, proto_error_o was never raised", $time);
    timeout_count++;
  end
endtask

`endif

// ==== tb_bulk_mem_bridge.sv ====
module tb_bulk_mem_bridge;

  localparam int ADDR_WIDTH = bridge_proto_pkg::DEF_ADDR_WIDTH;
  localparam int STORE_WORDS = 2 ** ADDR_WIDTH;

  logic clock_i = 1'b0;
  logic rst_n_i;
  logic s_tvalid_i;
  logic s_tready_o;
  logic s_tlast_i;
  logic [7:0] s_tdata_i;
  logic m_tvalid_o;
  logic m_tready_i = 1'b1;
  logic m_tlast_o;
  logic [7:0] m_tdata_o;
  logic proto_error_o;

  logic [31:0] ref_mem [STORE_WORDS];  // Model of the word store
  logic [7:0] payload_q [$];
  logic [7:0] frame_q [$];
  logic [7:0] exp_data_q [$];
  logic exp_last_q [$];
  logic [15:0] data_lfsr = 16'd35;   // Payload bytes
  logic [15:0] ready_lfsr = 16'd35;  // Bulk IN stalls
  logic ready_random = 1'b0;
  int check_count = 0;
  int error_count = 0;
  int timeout_count = 0;

  always #5 clock_i = ~clock_i;

  bulk_mem_bridge #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .FIFO_DEPTH(bridge_proto_pkg::DEF_FIFO_DEPTH)
  ) bulk_mem_bridge_i (
    .clock_i      (clock_i),
    .rst_n_i      (rst_n_i),
    .s_tvalid_i   (s_tvalid_i),
    .s_tready_o   (s_tready_o),
    .s_tlast_i    (s_tlast_i),
    .s_tdata_i    (s_tdata_i),
    .m_tvalid_o   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .m_tlast_o    (m_tlast_o),
    .m_tdata_o    (m_tdata_o),
    .proto_error_o(proto_error_o)
  );

  // Packs payload bytes LSB first and leaves missing upper bytes of the final word zero
  function automatic void ref_write(input int addr, input int nbytes);
    logic [31:0] word;
    int w;
    int b;
    for (w = 0; w < (nbytes + 3) / 4; w++) begin
      word = '0;
      for (b = 0; b < 4 && w * 4 + b < nbytes; b++) begin
        word = word | (32'(payload_q[w * 4 + b]) << (8 * b));
      end
      ref_mem[ADDR_WIDTH'(addr + w)] = word;  // Wraps at the top
    end
  endfunction

  // Queues the bulk IN bytes of a read frame where count 0 means 256 words
  function automatic void expect_read(input int addr, input int count);
    logic [31:0] word;
    int words;
    int w;
    int b;
    words = (count == 0) ? 256 : count;
    for (w = 0; w < words; w++) begin
      word = ref_mem[ADDR_WIDTH'(addr + w)];
      for (b = 0; b < 4; b++) begin
        exp_data_q.push_back(8'(word >> (8 * b)));
        exp_last_q.push_back(w == words - 1 && b == 3);
      end
    end
  endfunction

  `include "tb_host_tasks.svh"

  task automatic send_write(input int addr, input int nbytes);
    int i;
    payload_q.delete();
    push_header(bridge_proto_pkg::OP_WRITE, addr, 0);  // Count unused
    for (i = 0; i < nbytes; i++) begin
      payload_q.push_back(random_byte());
      frame_q.push_back(payload_q[i]);
    end
    ref_write(addr, nbytes);
    send_frame();
  endtask

  task automatic send_read(input int addr, input int count);
    push_header(bridge_proto_pkg::OP_READ, addr, count);
    expect_read(addr, count);
    send_frame();
    wait_read_done(20000);
  endtask

  task automatic apply_reset();
    @(posedge clock_i);
    rst_n_i <= 1'b0;
    repeat (4) @(posedge clock_i);
    rst_n_i <= 1'b1;
  endtask

  always @(posedge clock_i) begin
    if (ready_random) begin
      m_tready_i <= ready_lfsr[0];
      ready_lfsr <= lfsr_next(ready_lfsr);
    end else begin
      m_tready_i <= 1'b1;
    end
  end

  // Inputs only move at posedge, so the negedge shows what the next edge takes
  always @(negedge clock_i) begin
    if (rst_n_i && m_tvalid_o && m_tready_i) begin
      if (exp_data_q.size() == 0) begin
        $display("Unexpected bulk IN byte %h at %0t", m_tdata_o, $time);
        error_count++;
      end else begin
        check_value("m_tdata_o", 32'(m_tdata_o), 32'(exp_data_q.pop_front()));
        check_value("m_tlast_o", 32'(m_tlast_o), 32'(exp_last_q.pop_front()));
      end
    end
  end

  initial begin
    int i;
    rst_n_i = 1'b0;
    s_tvalid_i = 1'b0;
    s_tlast_i = 1'b0;
    s_tdata_i = '0;
    apply_reset();
    @(negedge clock_i);
    check_value("s_tready_o", 32'(s_tready_o), 32'd1);
    check_value("m_tvalid_o", 32'(m_tvalid_o), 32'd0);
    check_value("proto_error_o", 32'(proto_error_o), 32'd0);
    send_write('h10, 32);
    send_read('h10, 8);
    send_write('h40, 12);  // Old contents under the partial word
    send_write('h40, 10);
    send_read('h40, 3);
    send_write('h1FE, 16);
    send_read('h1FE, 4);
    // Upper half of the store read back whole with a random IN stall pattern
    send_write('h100, 1024);
    ready_random <= 1'b1;
    send_read('h100, 0);
    ready_random <= 1'b0;
    check_value("proto_error_o", 32'(proto_error_o), 32'd0);  // Valid frames only so far
    apply_reset();
    push_header(8'h33, 0, 1);
    frame_q.push_back(8'h5A);
    send_frame();
    wait_for_error(100);
    // Dropped frame must end at tlast so the next frames decode
    send_write('h20, 8);
    send_read('h20, 2);
    check_value("proto_error_o", 32'(proto_error_o), 32'd1);  // Sticky until reset
    apply_reset();
    @(negedge clock_i);
    check_value("proto_error_o", 32'(proto_error_o), 32'd0);
    frame_q.push_back(bridge_proto_pkg::OP_READ);
    for (i = 1; i < bridge_proto_pkg::HDR_BYTES - 1; i++) frame_q.push_back(8'(i));
    send_frame();
    wait_for_error(100);
    send_write('h3, 20);
    send_read('h3, 5);
    repeat (20) @(negedge clock_i);  // Room for any stray IN byte
    $display("Checks %0d, check errors %0d, timeouts %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
bridge_proto_pkg.sv
bridge_types_pkg.sv
stream_fifo.sv
bulk_frame_decoder.sv
word_store.sv
bulk_in_serializer.sv
bulk_mem_bridge.sv
tb_bulk_mem_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_bulk_mem_bridge \
  -o tb_sim > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0
